/* src/mmu_pkg.sv */
/* sizes and record types shared by the Sv32 TLB hierarchy
   imported by every RTL module and by the testbench */
`default_nettype none

package mmu_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////
  localparam int VLEN             = 32;  // Sv32 virtual address
  localparam int PLEN             = 34;  // Sv32 physical address
  localparam int ASID_W           = 9;
  localparam int L1_TLB_ENTRIES   = 4;
  localparam int SHARED_TLB_DEPTH = 64;  // sets
  localparam int SHARED_TLB_WAYS  = 2;

  // derived widths
  localparam int VPN_W     = VLEN - 12;
  localparam int PPN_W     = PLEN - 12;
  localparam int SET_IDX_W = $clog2(SHARED_TLB_DEPTH);
  localparam int WAY_IDX_W = (SHARED_TLB_WAYS > 1) ? $clog2(SHARED_TLB_WAYS) : 1;
  localparam int L1_IDX_W  = (L1_TLB_ENTRIES > 1) ? $clog2(L1_TLB_ENTRIES) : 1;

  //////////////////////////////
  // records
  //////////////////////////////
  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;  // software bits, unused here
    logic             d;
    logic             a;
    logic             g;    // global, matches any ASID
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } pte_t;

  typedef struct packed {
    logic [ASID_W-1:0] asid;
    logic [9:0]        vpn1;
    logic [9:0]        vpn0;
    logic              is_4m;
  } shared_tag_t;

  // one translation, walker -> shared TLB -> L1 TLB
  typedef struct packed {
    logic              valid;
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
    logic              is_4m;
    pte_t              pte;
  } tlb_update_t;

  // an L1 lookup as the shared TLB sees it
  typedef struct packed {
    logic            access;  // translated access in progress
    logic            hit;     // L1 already hits
    logic [VLEN-1:0] vaddr;
  } lookup_req_t;

  typedef enum logic {
    SRC_ITLB = 1'b0,
    SRC_DTLB = 1'b1
  } tlb_src_e;

endpackage

`default_nettype wire

/* src/tlb_way_ram.sv */
/* single-port storage for one way of the shared TLB, tag or PTE
   read data arrives one cycle after req_i and holds until the next read */
`timescale 1ns/1ns
`default_nettype none

module tlb_way_ram #(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_WORDS  = 64
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0]        wdata_i,
  output logic [DATA_WIDTH-1:0]        rdata_o
);

  logic [DATA_WIDTH-1:0] mem_q [NUM_WORDS];
  logic [DATA_WIDTH-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];  // kept until the next read
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* src/l1_tlb.sv */
/* fully associative first-level TLB, one per side (instruction and data)
   combinational lookup, bare-mode bypass, round-robin fill from the shared TLB */
`timescale 1ns/1ns
`default_nettype none

module l1_tlb
  import mmu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              translation_en_i,
  input  logic [ASID_W-1:0] asid_i,
  input  logic              access_i,
  input  logic [VLEN-1:0]   vaddr_i,
  input  tlb_update_t       update_i,    // fill from the shared TLB
  output logic              hit_o,
  output logic [PLEN-1:0]   paddr_o,
  output lookup_req_t       miss_req_o
);

  tlb_update_t [L1_TLB_ENTRIES-1:0] entry_q;  // payload only, valid kept apart
  logic [L1_TLB_ENTRIES-1:0]        valid_q;
  logic [L1_IDX_W-1:0]              fill_ptr_q;

  logic [L1_TLB_ENTRIES-1:0] match;
  logic                      tr_hit;
  logic [PLEN-1:0]           tr_paddr;
  logic                      fill;

  //////////////////////////////
  // lookup
  //////////////////////////////
  always_comb begin
    for (int i = 0; i < L1_TLB_ENTRIES; i++) begin
      match[i] = valid_q[i]
               & ((entry_q[i].asid == asid_i) | entry_q[i].pte.g)
               & (entry_q[i].vpn[VPN_W-1:10] == vaddr_i[VLEN-1:22])
               & (entry_q[i].is_4m | (entry_q[i].vpn[9:0] == vaddr_i[21:12]));
    end
  end

  // lowest matching entry wins
  always_comb begin
    tr_hit   = 1'b0;
    tr_paddr = '0;
    for (int i = L1_TLB_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        tr_hit = 1'b1;
        if (entry_q[i].is_4m) begin
          tr_paddr = {entry_q[i].pte.ppn[PPN_W-1:10], vaddr_i[21:0]};  // 4 MiB
        end else begin
          tr_paddr = {entry_q[i].pte.ppn, vaddr_i[11:0]};
        end
      end
    end
  end

  // bare mode passes the address straight through
  assign hit_o   = access_i & (~translation_en_i | tr_hit);
  assign paddr_o = translation_en_i ? tr_paddr : {{(PLEN - VLEN){1'b0}}, vaddr_i};

  assign miss_req_o.access = access_i & translation_en_i;
  assign miss_req_o.hit    = tr_hit;
  assign miss_req_o.vaddr  = vaddr_i;

  //////////////////////////////
  // fill and flush
  //////////////////////////////
  assign fill = update_i.valid & translation_en_i & ~flush_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q    <= '0;
      fill_ptr_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill) begin
      valid_q[fill_ptr_q] <= 1'b1;
      if (fill_ptr_q == L1_IDX_W'(L1_TLB_ENTRIES - 1)) begin
        fill_ptr_q <= '0;
      end else begin
        fill_ptr_q <= fill_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill) begin
      entry_q[fill_ptr_q] <= update_i;
    end
  end

endmodule

`default_nettype wire

/* src/shared_tlb.sv */
/* two-way second-level TLB behind both L1 TLBs
   arbitrates their misses, looks up the set RAMs, requests walks and takes refills */
`timescale 1ns/1ns
`default_nettype none

module shared_tlb
  import mmu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              translation_en_i,
  input  logic [ASID_W-1:0] asid_i,
  input  lookup_req_t       itlb_req_i,
  input  lookup_req_t       dtlb_req_i,
  output tlb_update_t       itlb_update_o,
  output tlb_update_t       dtlb_update_o,
  output logic              walk_req_o,
  output logic [VLEN-1:0]   walk_vaddr_o,
  input  tlb_update_t       walk_update_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,  // set read in flight
    ST_WALK     // waiting for the walker
  } state_e;

  state_e   state_q, state_d;
  tlb_src_e src_q;                          // owner of the pending lookup
  logic [VLEN-1:0]            vaddr_q;
  logic [ASID_W-1:0]          asid_q;
  logic [SHARED_TLB_WAYS-1:0] rd_valid_q;   // valid bits of the set being read

  logic [SHARED_TLB_DEPTH-1:0][SHARED_TLB_WAYS-1:0] valid_q;

  logic            dtlb_miss;
  logic            itlb_miss;
  logic            rd_en;
  tlb_src_e        src_sel;
  logic [VLEN-1:0] sel_vaddr;
  logic [SET_IDX_W-1:0] rd_set;

  logic                       wr_en;
  logic [SET_IDX_W-1:0]       wr_set;
  logic [SHARED_TLB_WAYS-1:0] way_valid;
  logic                       all_valid;
  logic [WAY_IDX_W-1:0]       inv_way;
  logic [WAY_IDX_W-1:0]       repl_way;
  logic [SHARED_TLB_WAYS-1:0] way_we;
  logic [7:0]                 lfsr_q;
  shared_tag_t                wr_tag;

  logic [SET_IDX_W-1:0]              ram_addr;
  shared_tag_t [SHARED_TLB_WAYS-1:0] tag_rd;
  pte_t [SHARED_TLB_WAYS-1:0]        pte_rd;

  logic [SHARED_TLB_WAYS-1:0] way_hit;
  logic                       lookup_hit;
  logic [WAY_IDX_W-1:0]       hit_way;
  tlb_update_t                hit_update;

  //////////////////////////////
  // miss arbiter
  //////////////////////////////
  // data side first, instruction side only while data is idle
  assign dtlb_miss = dtlb_req_i.access & ~dtlb_req_i.hit;
  assign itlb_miss = itlb_req_i.access & ~itlb_req_i.hit & ~dtlb_req_i.access;
  assign src_sel   = dtlb_miss ? SRC_DTLB : SRC_ITLB;
  assign sel_vaddr = dtlb_miss ? dtlb_req_i.vaddr : itlb_req_i.vaddr;
  assign rd_set    = sel_vaddr[12 +: SET_IDX_W];

  // a refill in the same cycle drops the read, requester just misses again
  assign rd_en = translation_en_i & (state_q == ST_IDLE) & (dtlb_miss | itlb_miss)
               & ~walk_update_i.valid & ~flush_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:   if (rd_en) state_d = ST_LOOKUP;
      ST_LOOKUP: state_d = walk_req_o ? ST_WALK : ST_IDLE;
      ST_WALK:   if (walk_update_i.valid) state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      src_q      <= SRC_ITLB;
      rd_valid_q <= '0;
    end else begin
      state_q <= state_d;
      if (flush_i) begin
        rd_valid_q <= '0;
      end else if (rd_en) begin
        src_q      <= src_sel;
        rd_valid_q <= valid_q[rd_set];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      vaddr_q <= sel_vaddr;
      asid_q  <= asid_i;
    end
  end

  //////////////////////////////
  // tag compare
  //////////////////////////////
  always_comb begin
    for (int w = 0; w < SHARED_TLB_WAYS; w++) begin
      way_hit[w] = rd_valid_q[w]
                 & ((tag_rd[w].asid == asid_q) | pte_rd[w].g)
                 & (tag_rd[w].vpn1 == vaddr_q[VLEN-1:22])
                 & (tag_rd[w].is_4m | (tag_rd[w].vpn0 == vaddr_q[21:12]));
    end
  end

  always_comb begin
    hit_way = '0;
    for (int w = SHARED_TLB_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_way = WAY_IDX_W'(w);
    end
  end

  assign lookup_hit = (state_q == ST_LOOKUP) & ~flush_i & (|way_hit);
  assign walk_req_o = (state_q == ST_LOOKUP) & ~flush_i & ~(|way_hit);  // single pulse
  assign walk_vaddr_o = vaddr_q;

  always_comb begin
    hit_update.valid = lookup_hit;
    hit_update.vpn   = vaddr_q[VLEN-1:12];
    hit_update.asid  = asid_q;
    hit_update.is_4m = tag_rd[hit_way].is_4m;
    hit_update.pte   = pte_rd[hit_way];

    // only the owner gets the strobe
    itlb_update_o       = hit_update;
    itlb_update_o.valid = lookup_hit & (src_q == SRC_ITLB);
    dtlb_update_o       = hit_update;
    dtlb_update_o.valid = lookup_hit & (src_q == SRC_DTLB);
  end

  //////////////////////////////
  // refill and replacement
  //////////////////////////////
  assign wr_en     = walk_update_i.valid & ~flush_i;
  assign wr_set    = walk_update_i.vpn[SET_IDX_W-1:0];
  assign way_valid = valid_q[wr_set];
  assign all_valid = &way_valid;

  // first invalid way, lowest index
  always_comb begin
    inv_way = '0;
    for (int w = SHARED_TLB_WAYS - 1; w >= 0; w--) begin
      if (!way_valid[w]) inv_way = WAY_IDX_W'(w);
    end
  end

  assign repl_way = all_valid ? lfsr_q[WAY_IDX_W-1:0] : inv_way;

  always_comb begin
    way_we = '0;
    if (wr_en) way_we[repl_way] = 1'b1;
  end

  // x^8 + x^6 + x^5 + x^4 + 1, steps only when a full set is replaced
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= 8'h01;
    end else if (wr_en && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;  // both levels cleared together
    end else if (wr_en) begin
      valid_q[wr_set][repl_way] <= 1'b1;
    end
  end

  assign wr_tag.asid  = walk_update_i.asid;
  assign wr_tag.vpn1  = walk_update_i.vpn[VPN_W-1:10];
  assign wr_tag.vpn0  = walk_update_i.vpn[9:0];
  assign wr_tag.is_4m = walk_update_i.is_4m;

  //////////////////////////////
  // way storage
  //////////////////////////////
  assign ram_addr = wr_en ? wr_set : rd_set;

  for (genvar w = 0; w < SHARED_TLB_WAYS; w++) begin : gen_way
    tlb_way_ram #(
      .DATA_WIDTH($bits(shared_tag_t)),
      .NUM_WORDS (SHARED_TLB_DEPTH)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .req_i  (way_we[w] | rd_en),
      .we_i   (way_we[w]),
      .addr_i (ram_addr),
      .wdata_i(wr_tag),
      .rdata_o(tag_rd[w])
    );

    tlb_way_ram #(
      .DATA_WIDTH($bits(pte_t)),
      .NUM_WORDS (SHARED_TLB_DEPTH)
    ) u_pte_ram (
      .clk_i  (clk_i),
      .req_i  (way_we[w] | rd_en),
      .we_i   (way_we[w]),
      .addr_i (ram_addr),
      .wdata_i(walk_update_i.pte),
      .rdata_o(pte_rd[w])
    );
  end

endmodule

`default_nettype wire

/* src/mmu_tlb_top.sv */
/* top of the translation cache, two L1 TLBs in front of one shared TLB
   the page-table walker sits outside on the walk ports */
`timescale 1ns/1ns
`default_nettype none

module mmu_tlb_top
  import mmu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              translation_en_i,
  input  logic [ASID_W-1:0] asid_i,

  // instruction side
  input  logic              itlb_access_i,
  input  logic [VLEN-1:0]   itlb_vaddr_i,
  output logic              itlb_hit_o,
  output logic [PLEN-1:0]   itlb_paddr_o,

  // data side
  input  logic              dtlb_access_i,
  input  logic [VLEN-1:0]   dtlb_vaddr_i,
  output logic              dtlb_hit_o,
  output logic [PLEN-1:0]   dtlb_paddr_o,

  // walker
  output logic              walk_req_o,
  output logic [VLEN-1:0]   walk_vaddr_o,
  input  tlb_update_t       walk_update_i
);

  lookup_req_t itlb_miss_req;
  lookup_req_t dtlb_miss_req;
  tlb_update_t itlb_update;
  tlb_update_t dtlb_update;

  l1_tlb u_itlb (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .translation_en_i(translation_en_i),
    .asid_i          (asid_i),
    .access_i        (itlb_access_i),
    .vaddr_i         (itlb_vaddr_i),
    .update_i        (itlb_update),
    .hit_o           (itlb_hit_o),
    .paddr_o         (itlb_paddr_o),
    .miss_req_o      (itlb_miss_req)
  );

  l1_tlb u_dtlb (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .translation_en_i(translation_en_i),
    .asid_i          (asid_i),
    .access_i        (dtlb_access_i),
    .vaddr_i         (dtlb_vaddr_i),
    .update_i        (dtlb_update),
    .hit_o           (dtlb_hit_o),
    .paddr_o         (dtlb_paddr_o),
    .miss_req_o      (dtlb_miss_req)
  );

  shared_tlb u_shared_tlb (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .translation_en_i(translation_en_i),
    .asid_i          (asid_i),
    .itlb_req_i      (itlb_miss_req),
    .dtlb_req_i      (dtlb_miss_req),
    .itlb_update_o   (itlb_update),
    .dtlb_update_o   (dtlb_update),
    .walk_req_o      (walk_req_o),
    .walk_vaddr_o    (walk_vaddr_o),
    .walk_update_i   (walk_update_i)
  );

endmodule

`default_nettype wire

/* test/mmu_tlb_props.sv */
/* concurrent checks on the walker request and the L1 hit outputs
   bound into the TLB top level by the testbench */
`timescale 1ns/1ns
`default_nettype none

module mmu_tlb_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic itlb_access_i,
  input logic itlb_hit_i,
  input logic dtlb_access_i,
  input logic dtlb_hit_i,
  input logic walk_req_i
);

  //////////////////////////////
  // walker request
  //////////////////////////////
  walk_req_single: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) walk_req_i |=> !walk_req_i
  ) else $error("walk_req_o stayed high for more than one cycle");

  walk_req_quiet_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |-> !walk_req_i  // async reset clears the FSM
  ) else $error("walk_req_o high during reset");

  //////////////////////////////
  // hit outputs
  //////////////////////////////
  itlb_hit_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) itlb_access_i |-> !$isunknown(itlb_hit_i)
  ) else $error("itlb_hit_o unknown during an access");

  dtlb_hit_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) dtlb_access_i |-> !$isunknown(dtlb_hit_i)
  ) else $error("dtlb_hit_o unknown during an access");

endmodule

`default_nettype wire

/* test/tb_mmu_tlb.sv */
/* testbench for the TLB hierarchy that plays both the core and the page-table walker
   random Sv32 mappings from a fixed seed with results checked against a page-table model */
`timescale 1ns/1ns
`default_nettype none

module tb_mmu_tlb
  import mmu_pkg::*;
();

  logic              clk = 1'b0;
  logic              rst_n;
  logic              flush;
  logic              translation_en;
  logic [ASID_W-1:0] asid;
  logic              itlb_access;
  logic [VLEN-1:0]   itlb_vaddr;
  logic              itlb_hit;
  logic [PLEN-1:0]   itlb_paddr;
  logic              dtlb_access;
  logic [VLEN-1:0]   dtlb_vaddr;
  logic              dtlb_hit;
  logic [PLEN-1:0]   dtlb_paddr;
  logic              walk_req;
  logic [VLEN-1:0]   walk_vaddr;
  tlb_update_t       walk_update = '0;

  // page-table model with one region per entry and a PPN per ASID
  logic [ASID_W-1:0] asid_tab [2];
  logic [9:0]        map_vpn1 [24];
  logic [9:0]        map_vpn0 [24];
  logic              map_4m   [24];
  logic              map_g    [24];
  logic [PPN_W-1:0]  map_ppn  [24][2];

  int                walk_cnt = 0;
  int                walk_wait = 0;
  logic [VLEN-1:0]   walk_va;
  logic [ASID_W-1:0] walk_asid;
  bit                verdict_given = 1'b0;

  always #20 clk = ~clk;

  mmu_tlb_top u_dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .flush_i         (flush),
    .translation_en_i(translation_en),
    .asid_i          (asid),
    .itlb_access_i   (itlb_access),
    .itlb_vaddr_i    (itlb_vaddr),
    .itlb_hit_o      (itlb_hit),
    .itlb_paddr_o    (itlb_paddr),
    .dtlb_access_i   (dtlb_access),
    .dtlb_vaddr_i    (dtlb_vaddr),
    .dtlb_hit_o      (dtlb_hit),
    .dtlb_paddr_o    (dtlb_paddr),
    .walk_req_o      (walk_req),
    .walk_vaddr_o    (walk_vaddr),
    .walk_update_i   (walk_update)
  );

  bind mmu_tlb_top mmu_tlb_props u_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .itlb_access_i(itlb_access_i),
    .itlb_hit_i   (itlb_hit_o),
    .dtlb_access_i(dtlb_access_i),
    .dtlb_hit_i   (dtlb_hit_o),
    .walk_req_i   (walk_req_o)
  );

  //////////////////////////////
  // page-table model
  //////////////////////////////
  function automatic int map_of(logic [VLEN-1:0] va);
    int idx;
    idx = -1;
    for (int i = 0; i < $size(map_vpn1); i++) begin
      if (map_vpn1[i] == va[31:22] && (map_4m[i] || map_vpn0[i] == va[21:12])) idx = i;
    end
    return idx;
  endfunction

  function automatic logic [PPN_W-1:0] ppn_of(int idx, logic [ASID_W-1:0] a);
    return map_ppn[idx][(a == asid_tab[1]) ? 1 : 0];
  endfunction

  function automatic logic [PLEN-1:0] expected_paddr(logic [VLEN-1:0] va, logic [ASID_W-1:0] a);
    int               idx;
    logic [PPN_W-1:0] ppn;
    idx = map_of(va);
    ppn = ppn_of(idx, a);
    if (map_4m[idx]) return {ppn[PPN_W-1:10], va[21:0]};  // superpage keeps 22 offset bits
    return {ppn, va[11:0]};
  endfunction

  function automatic tlb_update_t expected_update(logic [VLEN-1:0] va, logic [ASID_W-1:0] a);
    tlb_update_t u;
    int          idx;
    idx = map_of(va);
    u = '0;
    u.valid   = 1'b1;
    u.vpn     = va[VLEN-1:12];
    u.asid    = a;
    u.is_4m   = map_4m[idx];
    u.pte.ppn = ppn_of(idx, a);
    u.pte.g   = map_g[idx];
    u.pte.d   = 1'b1;
    u.pte.a   = 1'b1;
    u.pte.x   = 1'b1;
    u.pte.w   = 1'b1;
    u.pte.r   = 1'b1;
    u.pte.v   = 1'b1;
    return u;
  endfunction

  function automatic logic [VLEN-1:0] random_va(int idx);
    logic [VLEN-1:0] va;
    va = $urandom;
    va[31:22] = map_vpn1[idx];
    if (!map_4m[idx]) va[21:12] = map_vpn0[idx];
    return va;
  endfunction

  task automatic build_table();
    asid_tab[0] = ASID_W'($urandom);
    asid_tab[1] = asid_tab[0] ^ 9'h0a5;
    for (int i = 0; i < $size(map_vpn1); i++) begin
      map_vpn1[i]   = {5'(i), 5'($urandom)};  // upper bits keep regions apart
      map_vpn0[i]   = 10'($urandom);
      map_4m[i]     = (i % 3 == 0);
      map_g[i]      = (i % 4 == 1);
      map_ppn[i][0] = PPN_W'($urandom);
      map_ppn[i][1] = map_g[i] ? map_ppn[i][0] : PPN_W'($urandom);
      if (map_4m[i]) begin
        map_ppn[i][0][9:0] = '0;  // superpage alignment
        map_ppn[i][1][9:0] = '0;
      end
    end
    map_vpn0[2][5:0] = ~map_vpn0[1][5:0];  // directed pages in different sets
  endtask

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic fail_stop(input string what);
    verdict_given = 1'b1;
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_paddr(input string name, input logic [PLEN-1:0] got, exp);
    if (got !== exp) begin
      fail_stop($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_vaddr(input string name, input logic [VLEN-1:0] got, exp);
    if (got !== exp) begin
      fail_stop($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_update(input string name, input tlb_update_t got, exp);
    if (got !== exp) begin
      fail_stop($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_walks(input string name, input int got, exp);
    if (got != exp) begin
      fail_stop($sformatf("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  //////////////////////////////
  // walker and fill monitor
  //////////////////////////////
  always @(negedge clk) begin
    if (walk_req === 1'b1) begin
      // data side owns the walk while it is accessing
      check_vaddr("walk_vaddr_o", walk_vaddr, dtlb_access ? dtlb_vaddr : itlb_vaddr);
      if (map_of(walk_vaddr) < 0) fail_stop("walk request for an address that is not mapped");
      walk_cnt++;
      walk_va   = walk_vaddr;
      walk_asid = asid;
      walk_wait = 1 + int'($urandom_range(4, 0));
    end
    if (u_dut.itlb_update.valid === 1'b1) begin
      check_update("itlb_update", u_dut.itlb_update, expected_update(itlb_vaddr, asid));
    end
    if (u_dut.dtlb_update.valid === 1'b1) begin
      check_update("dtlb_update", u_dut.dtlb_update, expected_update(dtlb_vaddr, asid));
    end
  end

  always @(posedge clk) begin
    #1;
    walk_update = '0;  // one-cycle strobe
    if (walk_wait > 0) begin
      walk_wait--;
      if (walk_wait == 0) walk_update = expected_update(walk_va, walk_asid);
    end
  end

  //////////////////////////////
  // core side
  //////////////////////////////
  task automatic drive_side(input bit data_side, input logic on, input logic [VLEN-1:0] va);
    if (data_side) begin
      dtlb_access = on;
      dtlb_vaddr  = va;
    end else begin
      itlb_access = on;
      itlb_vaddr  = va;
    end
  endtask

  // bare mode hits at once and translated accesses within 200 cycles
  task automatic translate(input bit data_side, input logic [VLEN-1:0] va);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    drive_side(data_side, 1'b1, va);
    @(negedge clk);
    while ((data_side ? dtlb_hit : itlb_hit) !== 1'b1) begin
      cycles++;
      if (!translation_en || cycles >= 200) begin
        fail_stop($sformatf("%s access to %h did not hit in time",
                            data_side ? "data" : "instruction", va));
      end
      @(negedge clk);
    end
    check_paddr(data_side ? "dtlb_paddr_o" : "itlb_paddr_o",
                data_side ? dtlb_paddr : itlb_paddr,
                translation_en ? expected_paddr(va, asid) : {{(PLEN - VLEN){1'b0}}, va});
    @(posedge clk);
    #1;
    drive_side(data_side, 1'b0, va);
  endtask

  task automatic translate_both(input logic [VLEN-1:0] iva, dva);
    int cycles;
    bit i_done;
    bit d_done;
    cycles = 0;
    i_done = 1'b0;
    d_done = 1'b0;
    @(posedge clk);
    #1;
    drive_side(1'b0, 1'b1, iva);
    drive_side(1'b1, 1'b1, dva);
    while (!(i_done && d_done)) begin
      @(negedge clk);
      if (!i_done && itlb_hit === 1'b1) begin
        check_paddr("itlb_paddr_o", itlb_paddr, expected_paddr(iva, asid));
        i_done = 1'b1;
      end
      if (!d_done && dtlb_hit === 1'b1) begin
        check_paddr("dtlb_paddr_o", dtlb_paddr, expected_paddr(dva, asid));
        d_done = 1'b1;
      end
      cycles++;
      if (cycles >= 200) fail_stop("simultaneous accesses did not both hit within 200 cycles");
      @(posedge clk);
      #1;
      if (i_done) itlb_access = 1'b0;
      if (d_done) dtlb_access = 1'b0;  // lets the instruction side through
    end
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    logic [VLEN-1:0] va;
    logic [VLEN-1:0] va_g;
    int              walks;
    void'($urandom(32'hc250));
    rst_n          = 1'b0;
    flush          = 1'b0;
    translation_en = 1'b0;
    asid           = '0;
    itlb_access    = 1'b0;
    itlb_vaddr     = '0;
    dtlb_access    = 1'b0;
    dtlb_vaddr     = '0;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int n = 0; n < 8; n++) translate(bit'(n % 2), $urandom);  // bare mode

    @(posedge clk);
    #1;
    translation_en = 1'b1;
    for (int n = 0; n < 40; n++) begin
      asid = asid_tab[$urandom_range(1, 0)];
      translate(bit'($urandom_range(1, 0)), random_va(int'($urandom_range(23, 0))));
    end

    // fresh page walks once and the other side then hits in the shared TLB
    pulse_flush();
    asid  = asid_tab[0];
    va    = random_va(2);
    va_g  = random_va(1);
    walks = walk_cnt;
    translate(1'b1, va);
    check_walks("walk_req_o pulses", walk_cnt, walks + 1);
    translate(1'b0, va);
    check_walks("walk_req_o pulses", walk_cnt, walks + 1);

    // after the ASID change the private page walks again but the global one does not
    translate(1'b1, va_g);
    @(posedge clk);
    #1;
    asid  = asid_tab[1];
    walks = walk_cnt;
    translate(1'b1, va);
    check_walks("walk_req_o pulses", walk_cnt, walks + 1);
    translate(1'b1, va_g);
    translate(1'b0, va_g);
    check_walks("walk_req_o pulses", walk_cnt, walks + 1);

    pulse_flush();
    walks = walk_cnt;
    translate(1'b1, va_g);
    check_walks("walk_req_o pulses", walk_cnt, walks + 1);

    for (int n = 0; n < 12; n++) begin
      asid = asid_tab[$urandom_range(1, 0)];
      translate_both(random_va(int'($urandom_range(23, 0))),
                     random_va(int'($urandom_range(23, 0))));
    end

    verdict_given = 1'b1;
    $display("Simulation PASSED");
    $finish;
  end

  final begin
    if (!verdict_given) begin
      $display("run stopped before the test sequence completed");
      $display("Simulation FAILED");
    end
  end

endmodule

`default_nettype wire

/* all.f */
src/mmu_pkg.sv
src/tlb_way_ram.sv
src/l1_tlb.sv
src/shared_tlb.sv
src/mmu_tlb_top.sv
test/mmu_tlb_props.sv
test/tb_mmu_tlb.sv

/* Makefile */
# Verilator flow for the TLB hierarchy testbench
TOP := tb_mmu_tlb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
